// File: rtl/sfp_tester_pkg.sv
// sfp tester shared definitions
`default_nettype none

package sfp_tester_pkg;

    // ------------------------------
    // counter type
    // ------------------------------
    typedef logic [31:0] count_t;   // period counter and divider width

    // ------------------------------
    // send period timing
    // ------------------------------
    localparam count_t DEF_PERIOD_1 = 32'd20_000_000;  // port 1 strobe start
    localparam count_t DEF_PERIOD_2 = 32'd23_355_443;  // port 2 window base

    // strobe window length in counts
    localparam count_t STROBE_LEN   = 32'd3;

    // counts past period 2 before the counter wraps
    localparam count_t WRAP_MARGIN  = 32'd10;

    // ------------------------------
    // clock dividers
    // ------------------------------
    localparam count_t DEF_BLINK_DIVIDE = 32'd25_000_000;   // 1 hz blink at 50 mhz
    localparam count_t DEF_I2C_DIVIDE   = 32'd124;          // expander i2c bit clock

endpackage

`default_nettype wire

// File: rtl/clock_divider.sv
// toggle clock divider
`timescale 1ns/1ps
`default_nettype none

module clock_divider
    import sfp_tester_pkg::*;
#(
    parameter count_t DIVIDE = DEF_BLINK_DIVIDE
)
(
    input  logic    clk_50_pll,
    input  logic    main_reset,

    output logic    clk_out
);

    // last count before the output toggles
    localparam count_t LAST_COUNT = DIVIDE - count_t'(1);

    count_t div_count;

    // ------------------------------
    // divide counter and toggle
    // ------------------------------
    always_ff @(posedge clk_50_pll, posedge main_reset)
    begin
        if (main_reset)
        begin
            div_count <= '0;
            clk_out   <= 1'b0;
        end
        else
        begin
            if (div_count == LAST_COUNT)
            begin
                div_count <= '0;
                clk_out   <= ~clk_out;      // half period done
            end
            else
            begin
                div_count <= div_count + count_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/send_sequencer.sv
// send request gating and period counter
`timescale 1ns/1ps
`default_nettype none

module send_sequencer
    import sfp_tester_pkg::*;
#(
    parameter count_t PERIOD_2 = DEF_PERIOD_2
)
(
    input  logic    clk_50_pll,
    input  logic    main_reset,

    input  logic    host_send_req,  // from host, async to our logic timing
    input  logic    mac_inited,
    input  logic    rx_ready,

    output logic    advance,        // link up, request held
    output logic    idle,           // link up, no request
    output count_t  count
);

    // counter returns to zero here
    localparam count_t WRAP_COUNT = PERIOD_2 + WRAP_MARGIN;

    logic send_req_q;
    logic link_up;

    // ------------------------------
    // request register
    // ------------------------------
    always_ff @(posedge clk_50_pll, posedge main_reset)
    begin
        if (main_reset)
        begin
            send_req_q <= 1'b0;
        end
        else
        begin
            send_req_q <= host_send_req;
        end
    end

    // ------------------------------
    // link gating
    // ------------------------------
    // requests only count once mac and transceiver are ready
    assign link_up = mac_inited & rx_ready;

    assign advance = link_up & send_req_q;
    assign idle    = link_up & ~send_req_q;

    // ------------------------------
    // period counter
    // ------------------------------
    always_ff @(posedge clk_50_pll, posedge main_reset)
    begin
        if (main_reset)
        begin
            count <= '0;
        end
        else if (advance)
        begin
            if (count == WRAP_COUNT)
            begin
                count <= '0;                    // end of period
            end
            else
            begin
                count <= count + count_t'(1);
            end
        end
        // holds when not advancing
    end

endmodule

`default_nettype wire

// File: rtl/burst_strobe.sv
// port 1 send strobe
`timescale 1ns/1ps
`default_nettype none

module burst_strobe
    import sfp_tester_pkg::*;
#(
    parameter count_t PERIOD_1 = DEF_PERIOD_1
)
(
    input  logic    clk_50_pll,
    input  logic    main_reset,

    input  logic    advance,
    input  logic    idle,
    input  count_t  count,

    output logic    cmd_send_1
);

    localparam count_t STOP_COUNT = PERIOD_1 + STROBE_LEN;   // window end

    // ------------------------------
    // fixed window in each period
    // ------------------------------
    always_ff @(posedge clk_50_pll, posedge main_reset)
    begin
        if (main_reset)
        begin
            cmd_send_1 <= 1'b0;
        end
        else if (advance)
        begin
            if (count == PERIOD_1)
            begin
                cmd_send_1 <= 1'b1;     // window opens
            end
            else if (count == STOP_COUNT)
            begin
                cmd_send_1 <= 1'b0;
            end
        end
        else if (idle)
        begin
            cmd_send_1 <= 1'b0;         // no request, no sending
        end
    end

endmodule

`default_nettype wire

// File: rtl/relay_strobe.sv
// port 2 send strobe
`timescale 1ns/1ps
`default_nettype none

module relay_strobe
    import sfp_tester_pkg::*;
#(
    parameter count_t PERIOD_2 = DEF_PERIOD_2
)
(
    input  logic    clk_50_pll,
    input  logic    main_reset,

    input  logic    advance,
    input  logic    idle,
    input  logic    data_saved_2,   // level from the receive side of port 2
    input  count_t  count,

    output logic    cmd_send_2
);

    localparam count_t DROP_COUNT = PERIOD_2 + STROBE_LEN;

    // ------------------------------
    // repeat or relay
    // ------------------------------
    always_ff @(posedge clk_50_pll, posedge main_reset)
    begin
        if (main_reset)
        begin
            cmd_send_2 <= 1'b0;
        end
        else if (advance)
        begin
            // host request held, keep sending
            if (!cmd_send_2)
            begin
                cmd_send_2 <= 1'b1;
            end
            else if (count == DROP_COUNT)
            begin
                cmd_send_2 <= 1'b0;             // one cycle gap per period
            end
        end
        else if (idle)
        begin
            // forward each saved packet
            if (data_saved_2 && !cmd_send_2)
            begin
                cmd_send_2 <= 1'b1;
            end
            else if (!data_saved_2)
            begin
                cmd_send_2 <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/sfp_tester_top.sv
// sfp send scheduler top
`timescale 1ns/1ps
`default_nettype none

module sfp_tester_top
    import sfp_tester_pkg::*;
#(
    parameter count_t PERIOD_1     = DEF_PERIOD_1,
    parameter count_t PERIOD_2     = DEF_PERIOD_2,
    parameter count_t BLINK_DIVIDE = DEF_BLINK_DIVIDE,
    parameter count_t I2C_DIVIDE   = DEF_I2C_DIVIDE
)
(
    input  logic    clk_50_pll,
    input  logic    main_reset,

    input  logic    host_send_req,
    input  logic    mac_inited,
    input  logic    rx_ready,
    input  logic    rx_locked_to_ref,
    input  logic    data_saved_2,

    output logic    cmd_send_1,
    output logic    cmd_send_2,

    output logic    blink_led,      // health blink
    output logic    clk_i2c,        // sfp expander bit clock

    output logic    sfp_txflt_led,
    output logic    sfp_rlos_led,
    output logic    sfp_prsn_led
);

    logic   advance;
    logic   idle;
    count_t count;

    // ------------------------------
    // scheduler
    // ------------------------------
    send_sequencer #(
        .PERIOD_2       (PERIOD_2)
    ) send_sequencer_i (
        .clk_50_pll     (clk_50_pll),
        .main_reset     (main_reset),
        .host_send_req  (host_send_req),
        .mac_inited     (mac_inited),
        .rx_ready       (rx_ready),
        .advance        (advance),
        .idle           (idle),
        .count          (count)
    );

    burst_strobe #(
        .PERIOD_1       (PERIOD_1)
    ) burst_strobe_i (
        .clk_50_pll     (clk_50_pll),
        .main_reset     (main_reset),
        .advance        (advance),
        .idle           (idle),
        .count          (count),
        .cmd_send_1     (cmd_send_1)
    );

    relay_strobe #(
        .PERIOD_2       (PERIOD_2)
    ) relay_strobe_i (
        .clk_50_pll     (clk_50_pll),
        .main_reset     (main_reset),
        .advance        (advance),
        .idle           (idle),
        .data_saved_2   (data_saved_2),
        .count          (count),
        .cmd_send_2     (cmd_send_2)
    );

    // ------------------------------
    // dividers
    // ------------------------------
    clock_divider #(
        .DIVIDE         (BLINK_DIVIDE)
    ) blink_divider (
        .clk_50_pll     (clk_50_pll),
        .main_reset     (main_reset),
        .clk_out        (blink_led)
    );

    clock_divider #(
        .DIVIDE         (I2C_DIVIDE)
    ) i2c_divider (
        .clk_50_pll     (clk_50_pll),
        .main_reset     (main_reset),
        .clk_out        (clk_i2c)
    );

    // status leds
    assign sfp_txflt_led = mac_inited;
    assign sfp_rlos_led  = rx_ready;
    assign sfp_prsn_led  = rx_locked_to_ref;    // transceiver locked to ref clock

endmodule

`default_nettype wire

// File: verification/sfp_tester_checks.svh
// testbench compare tasks and random source
`ifndef SFP_TESTER_CHECKS_SVH
`define SFP_TESTER_CHECKS_SVH

// ------------------------------
// compare tasks
// ------------------------------
task automatic check_level(
    input string name,
    input logic  got,
    input logic  expected
);
    if (got !== expected)
    begin
        abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected));
    end
endtask

task automatic check_count(
    input string  name,
    input count_t got,
    input count_t expected
);
    if (got !== expected)
    begin
        abort_run($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected));
    end
endtask

// ------------------------------
// linear congruential generator
// ------------------------------
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
endfunction

`endif

// File: verification/sfp_tester_tb.sv
// sfp send scheduler testbench
`timescale 1ns/1ps
`default_nettype none

module sfp_tester_tb
    import sfp_tester_pkg::*;
();

    localparam int     CLK_PERIOD   = 40;
    localparam int     RESET_CYCLES = 2;

    // small timing so every window is reached quickly
    localparam count_t TB_PERIOD_1     = 32'd8;
    localparam count_t TB_PERIOD_2     = 32'd12;
    localparam count_t TB_BLINK_DIVIDE = 32'd5;
    localparam count_t TB_I2C_DIVIDE   = 32'd3;

    // two full periods of each divider, worst case
    localparam int unsigned DIVIDER_CYCLES = 4 * (TB_BLINK_DIVIDE + TB_I2C_DIVIDE);

    typedef struct packed {
        logic       mac_inited;
        logic       rx_ready;
        logic       host_send_req;
        logic       data_saved_2;
        logic [7:0] hold;
        logic       exp_send_1;
        logic       exp_send_2;
        count_t     exp_count;
    } step_t;

    localparam int NUM_STEPS = 21;

    // mac, rx, req, saved, hold | cmd_send_1, cmd_send_2, period count
    localparam step_t STEPS [0:NUM_STEPS-1] = '{
        '{1'b0, 1'b0, 1'b0, 1'b0, 8'd2, 1'b0, 1'b0, 32'd0},   // link down after reset
        '{1'b1, 1'b0, 1'b1, 1'b0, 8'd4, 1'b0, 1'b0, 32'd0},   // request without rx ready
        '{1'b1, 1'b1, 1'b1, 1'b0, 8'd8, 1'b0, 1'b1, 32'd8},
        '{1'b1, 1'b1, 1'b1, 1'b0, 8'd1, 1'b1, 1'b1, 32'd9},   // port 1 window opens
        '{1'b1, 1'b1, 1'b1, 1'b0, 8'd2, 1'b1, 1'b1, 32'd11},
        '{1'b1, 1'b1, 1'b1, 1'b0, 8'd1, 1'b0, 1'b1, 32'd12},  // closed after 3 cycles
        '{1'b1, 1'b1, 1'b1, 1'b0, 8'd4, 1'b0, 1'b0, 32'd16},  // port 2 gap
        '{1'b1, 1'b1, 1'b1, 1'b0, 8'd1, 1'b0, 1'b1, 32'd17},
        '{1'b1, 1'b1, 1'b1, 1'b0, 8'd6, 1'b0, 1'b1, 32'd0},   // counter wrap
        '{1'b1, 1'b1, 1'b1, 1'b0, 8'd8, 1'b0, 1'b1, 32'd8},
        '{1'b1, 1'b1, 1'b1, 1'b0, 8'd1, 1'b1, 1'b1, 32'd9},   // second window
        '{1'b1, 1'b1, 1'b0, 1'b0, 8'd3, 1'b0, 1'b0, 32'd10},  // request dropped
        '{1'b1, 1'b1, 1'b0, 1'b1, 8'd2, 1'b0, 1'b1, 32'd10},
        '{1'b1, 1'b1, 1'b0, 1'b0, 8'd1, 1'b0, 1'b0, 32'd10},
        '{1'b1, 1'b1, 1'b0, 1'b1, 8'd1, 1'b0, 1'b1, 32'd10},
        '{1'b0, 1'b1, 1'b0, 1'b0, 8'd2, 1'b0, 1'b1, 32'd10},  // mac down, all held
        '{1'b1, 1'b1, 1'b1, 1'b0, 8'd1, 1'b0, 1'b0, 32'd10},  // last idle edge
        '{1'b1, 1'b1, 1'b1, 1'b0, 8'd1, 1'b0, 1'b1, 32'd11},
        '{1'b1, 1'b1, 1'b1, 1'b0, 8'd5, 1'b0, 1'b0, 32'd16},
        '{1'b1, 1'b1, 1'b1, 1'b0, 8'd1, 1'b0, 1'b1, 32'd17},
        '{1'b1, 1'b0, 1'b1, 1'b0, 8'd3, 1'b0, 1'b1, 32'd17}
    };

    logic clk_50_pll;
    logic main_reset;
    logic host_send_req;
    logic mac_inited;
    logic rx_ready;
    logic rx_locked_to_ref;
    logic data_saved_2;
    logic cmd_send_1;
    logic cmd_send_2;
    logic blink_led;
    logic clk_i2c;
    logic sfp_txflt_led;
    logic sfp_rlos_led;
    logic sfp_prsn_led;

    sfp_tester_top #(
        .PERIOD_1         (TB_PERIOD_1),
        .PERIOD_2         (TB_PERIOD_2),
        .BLINK_DIVIDE     (TB_BLINK_DIVIDE),
        .I2C_DIVIDE       (TB_I2C_DIVIDE)
    ) sfp_tester_top_i (
        .clk_50_pll       (clk_50_pll),
        .main_reset       (main_reset),
        .host_send_req    (host_send_req),
        .mac_inited       (mac_inited),
        .rx_ready         (rx_ready),
        .rx_locked_to_ref (rx_locked_to_ref),
        .data_saved_2     (data_saved_2),
        .cmd_send_1       (cmd_send_1),
        .cmd_send_2       (cmd_send_2),
        .blink_led        (blink_led),
        .clk_i2c          (clk_i2c),
        .sfp_txflt_led    (sfp_txflt_led),
        .sfp_rlos_led     (sfp_rlos_led),
        .sfp_prsn_led     (sfp_prsn_led)
    );

    initial
    begin
        clk_50_pll = 1'b0;
        forever #(CLK_PERIOD / 2) clk_50_pll = ~clk_50_pll;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "run stopped at first failure");
    endtask

    `include "sfp_tester_checks.svh"

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic int unsigned total_hold();
        int unsigned sum;
        sum = 0;
        for (int i = 0; i < NUM_STEPS; i++)
        begin
            sum = sum + 32'(STEPS[i].hold);
        end
        return sum;
    endfunction

    function automatic logic divider_level(input logic use_i2c);
        return use_i2c ? clk_i2c : blink_led;
    endfunction

    // cycles between two rising edges of a divider output
    task automatic measure_period(input logic use_i2c, output count_t cycles);
        logic   prev;
        logic   cur;
        int     rises;
        count_t n;
        rises = 0;
        n     = '0;
        prev  = divider_level(use_i2c);
        while (rises < 2)
        begin
            @(negedge clk_50_pll);
            cur = divider_level(use_i2c);
            if (rises == 1)
            begin
                n = n + count_t'(1);
            end
            if (cur && !prev)
            begin
                rises++;
            end
            prev = cur;
        end
        cycles = n;
    endtask

    // ------------------------------
    // stimulus and checks
    // ------------------------------
    initial
    begin
        logic [31:0] lcg_state;
        logic        lock_level;
        count_t      period;
        step_t       step;

        main_reset       = 1'b1;
        host_send_req    = 1'b0;
        mac_inited       = 1'b0;
        rx_ready         = 1'b0;
        rx_locked_to_ref = 1'b0;
        data_saved_2     = 1'b0;
        lcg_state        = 32'd34;

        repeat (RESET_CYCLES) @(posedge clk_50_pll);
        @(negedge clk_50_pll);
        check_level("cmd_send_1", cmd_send_1, 1'b0);
        check_level("cmd_send_2", cmd_send_2, 1'b0);
        check_level("blink_led", blink_led, 1'b0);
        check_level("clk_i2c", clk_i2c, 1'b0);
        check_count("count", sfp_tester_top_i.count, '0);
        main_reset = 1'b0;

        for (int i = 0; i < NUM_STEPS; i++)
        begin
            step       = STEPS[i];
            lcg_state  = lcg_next(lcg_state);
            lock_level = lcg_state[16];     // random lock level

            mac_inited       = step.mac_inited;
            rx_ready         = step.rx_ready;
            host_send_req    = step.host_send_req;
            data_saved_2     = step.data_saved_2;
            rx_locked_to_ref = lock_level;

            repeat (step.hold) @(negedge clk_50_pll);

            check_level("cmd_send_1", cmd_send_1, step.exp_send_1);
            check_level("cmd_send_2", cmd_send_2, step.exp_send_2);
            check_count("count", sfp_tester_top_i.count, step.exp_count);
            check_level("sfp_txflt_led", sfp_txflt_led, step.mac_inited);
            check_level("sfp_rlos_led", sfp_rlos_led, step.rx_ready);
            check_level("sfp_prsn_led", sfp_prsn_led, lock_level);
        end

        // divider periods are twice the divide value
        measure_period(1'b0, period);
        check_count("blink_led period", period, count_t'(2) * TB_BLINK_DIVIDE);
        measure_period(1'b1, period);
        check_count("clk_i2c period", period, count_t'(2) * TB_I2C_DIVIDE);

        $display("** PASS **");
        $finish;
    end

    // watchdog
    initial
    begin
        int unsigned budget;
        budget = 2 * (RESET_CYCLES + total_hold() + DIVIDER_CYCLES);
        #(budget * CLK_PERIOD);
        abort_run("timeout: watchdog expired before all tests finished");
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+verification
rtl/sfp_tester_pkg.sv
rtl/clock_divider.sv
rtl/send_sequencer.sv
rtl/burst_strobe.sv
rtl/relay_strobe.sv
rtl/sfp_tester_top.sv
verification/sfp_tester_tb.sv

// File: Makefile
# Verilator build for the sfp send scheduler

FLIST := flist.f
LOG   := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f $(FLIST) --top-module sfp_tester_top

sim:
	verilator --binary --timing -f $(FLIST) --top-module sfp_tester_tb -o sfp_tester_sim
	./obj_dir/sfp_tester_sim | tee $(LOG)
	grep -qF '** PASS **' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
